// File: uniboard_top.f
logic/uniboard_pkg.sv
logic/uart_receiver.sv
logic/frame_decoder.sv
logic/register_bus_master.sv
logic/peripheral_block.sv
logic/frame_encoder.sv
logic/uart_transmitter.sv
logic/uniboard_top.sv
dv/uniboard_assertions.sv
dv/uniboard_tb.sv

// File: dv/uniboard_tb.sv
// uniboard command path testbench
`default_nettype none

module uniboard_tb
	import uniboard_pkg::*;
();

	// wire bytes per frame at worst, all six body bytes escaped
	localparam int MAX_WIRE_BYTES = 14;
	// ten bits plus a few gap cycles
	localparam int BYTE_CYCLES = 10 * BAUD_DIV + 8;
	// command out and reply back, overlapping at most
	localparam int FRAME_CYCLES = 2 * MAX_WIRE_BYTES * BYTE_CYCLES;
	localparam int N_FRAMES = 16;
	localparam int TIMEOUT_CYCLES = 2 * N_FRAMES * FRAME_CYCLES + 64;

	logic clk_12MHz;
	logic reset;
	logic uart_rx;
	logic uart_tx;

	int value_errors = 0;
	int other_errors = 0;
	int cycle_count;
	logic [31:0] lcg_state = 32'd42452;

	// model of the four scratch words
	reg_data_t shadow [4];

	byte_t cmd_wire[$];
	byte_t exp_body[$];
	byte_t reply_raw[$];
	byte_t reply_body[$];
	reg_data_t exp_data;
	reg_size_t exp_size;

	uniboard_top dut0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx)
	);

	initial
	begin
		clk_12MHz = 1'b0;
		forever #20 clk_12MHz = ~clk_12MHz;
	end

	function reg_data_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic bit is_marker(input byte_t b);
		return (b == START_BYTE) || (b == END_BYTE) || (b == ESCAPE_BYTE);
	endfunction

	task automatic check_byte(input byte_t got, input byte_t want, input string what);
		if (got !== want)
		begin
			$display("Fail at %0t: %s got 0x%02h, expected 0x%02h", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic check_data(input reg_data_t got, input reg_data_t want, input string what);
		if (got !== want)
		begin
			$display("Fail at %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic check_size(input reg_size_t got, input reg_size_t want, input string what);
		if (got !== want)
		begin
			$display("Fail at %0t: %s got %0d, expected %0d", $time, what, got, want);
			value_errors++;
		end
	endtask

	// one character, start bit then lsb first, entered on a falling edge
	task automatic send_uart_byte(input byte_t value);
		uart_rx = 1'b0;
		repeat (BAUD_DIV) @(negedge clk_12MHz);
		for (int i = 0; i < 8; i++)
		begin
			uart_rx = value[i];
			repeat (BAUD_DIV) @(negedge clk_12MHz);
		end
		uart_rx = 1'b1;
		repeat (BAUD_DIV) @(negedge clk_12MHz);
	endtask

	task automatic send_wire();
		foreach (cmd_wire[i])
			send_uart_byte(cmd_wire[i]);
	endtask

	task automatic push_escaped(input byte_t b);
		if (is_marker(b))
			cmd_wire.push_back(ESCAPE_BYTE);
		cmd_wire.push_back(b);
	endtask

	// start, read flag and peripheral, register, write bytes low first, end
	task automatic build_command(input bit read, input periph_num_t periph, input reg_num_t regn,
		input reg_data_t data, input int nbytes);
		cmd_wire.delete();
		cmd_wire.push_back(START_BYTE);
		push_escaped({read, periph});
		push_escaped(regn);
		for (int i = 0; i < nbytes; i++)
			push_escaped(data[8*i +: 8]);
		cmd_wire.push_back(END_BYTE);
	endtask

	task automatic expect_reply(input bit read, input periph_num_t periph, input reg_num_t regn,
		input reg_data_t data, input reg_size_t size);
		exp_body.delete();
		exp_body.push_back({read, periph});
		exp_body.push_back(regn);
		for (int i = 0; i < size; i++)
			exp_body.push_back(data[8*i +: 8]);
		exp_data = data;
		exp_size = size;
	endtask

	// waits up to limit cycles for a start bit, samples mid bit
	task automatic read_uart_byte(input int limit, output byte_t value, output bit found);
		int waited;
		waited = 0;
		value = '0;
		found = 1'b0;
		while (uart_tx !== 1'b0 && waited < limit)
		begin
			@(negedge clk_12MHz);
			waited++;
		end
		if (uart_tx === 1'b0)
		begin
			found = 1'b1;
			// edge seen half a cycle late, so mid start bit is close
			repeat (BAUD_DIV / 2 - 1) @(negedge clk_12MHz);
			for (int i = 0; i < 8; i++)
			begin
				repeat (BAUD_DIV) @(negedge clk_12MHz);
				value[i] = uart_tx;
			end
			repeat (BAUD_DIV) @(negedge clk_12MHz);
			if (uart_tx !== 1'b1)
			begin
				$display("reply byte 0x%02h has no stop bit at time %0t", value, $time);
				other_errors++;
			end
		end
	endtask

	// raw wire bytes plus the unescaped body between the markers
	task automatic receive_reply(input bit want_reply);
		byte_t b;
		bit found;
		bit escaped;
		bit done;
		reply_raw.delete();
		reply_body.delete();
		read_uart_byte(FRAME_CYCLES, b, found);
		if (!found)
		begin
			if (want_reply)
			begin
				$display("no reply start bit within %0d cycles at time %0t", FRAME_CYCLES, $time);
				other_errors++;
			end
			return;
		end
		if (!want_reply)
		begin
			$display("a reply appeared where none was expected at time %0t", $time);
			other_errors++;
		end
		reply_raw.push_back(b);
		escaped = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			read_uart_byte(4 * BAUD_DIV, b, found);
			if (!found || reply_raw.size() > 2 * MAX_WIRE_BYTES)
			begin
				$display("reply stopped before its end byte at time %0t", $time);
				other_errors++;
				done = 1'b1;
			end
			else
			begin
				reply_raw.push_back(b);
				if (escaped)
				begin
					reply_body.push_back(b);
					escaped = 1'b0;
				end
				else if (b == ESCAPE_BYTE)
					escaped = 1'b1;
				else if (b == END_BYTE)
					done = 1'b1;
				else
					reply_body.push_back(b);
			end
		end
	endtask

	task automatic compare_reply();
		byte_t expected[$];
		reg_data_t got_data;
		expected.push_back(START_BYTE);
		foreach (exp_body[i])
		begin
			// markers inside the body travel behind an escape
			if (is_marker(exp_body[i]))
				expected.push_back(ESCAPE_BYTE);
			expected.push_back(exp_body[i]);
		end
		expected.push_back(END_BYTE);
		if (reply_raw.size() != expected.size())
		begin
			$display("reply has %0d wire bytes where %0d were expected, at time %0t",
				reply_raw.size(), expected.size(), $time);
			other_errors++;
		end
		for (int i = 0; i < expected.size() && i < reply_raw.size(); i++)
			check_byte(reply_raw[i], expected[i], "reply wire byte");
		if (reply_body.size() < 2)
		begin
			$display("reply body too short to hold a header at time %0t", $time);
			other_errors++;
		end
		else
		begin
			check_size(reg_size_t'(reply_body.size() - 2), exp_size, "reply data byte count");
			got_data = '0;
			for (int i = 2; i < reply_body.size() && i < 6; i++)
				got_data[8*(i-2) +: 8] = reply_body[i];
			check_data(got_data, exp_data, "reply data");
		end
	endtask

	// command out and reply watch run side by side
	task automatic exchange(input bit want_reply);
		fork
			send_wire();
			receive_reply(want_reply);
		join
		if (want_reply && reply_raw.size() > 0)
			compare_reply();
	endtask

	task automatic expect_scratch_read(input reg_num_t regn);
		expect_reply(1'b1, SCRATCH_PERIPH, regn, shadow[regn[1:0]], SCRATCH_REG_SIZE);
	endtask

	// expected reply from the framing rules and the scratch model
	task automatic run_command(input bit read, input periph_num_t periph, input reg_num_t regn,
		input reg_data_t data, input int nbytes);
		reg_data_t wdata;
		wdata = '0;
		// missing write bytes count as zero
		for (int i = 0; i < nbytes && i < 4; i++)
			wdata[8*i +: 8] = data[8*i +: 8];
		if (periph == SCRATCH_PERIPH)
		begin
			if (!read)
				shadow[regn[1:0]] = wdata;
			expect_reply(read, periph, regn, shadow[regn[1:0]], SCRATCH_REG_SIZE);
		end
		else
			expect_reply(read, periph, regn, '0, '0);
		build_command(read, periph, regn, data, nbytes);
		exchange(1'b1);
	endtask

	// line rests high with no frame sent
	task automatic test_idle_after_reset();
		cmd_wire.delete();
		if (uart_tx !== 1'b1)
		begin
			$display("uart_tx is not high after reset at time %0t", $time);
			other_errors++;
		end
		exchange(1'b0);
		if (uart_tx !== 1'b1)
		begin
			$display("uart_tx left the idle level without a frame at time %0t", $time);
			other_errors++;
		end
	endtask

	task automatic test_scratch_writes();
		for (int r = 0; r < 4; r++)
			run_command(1'b0, SCRATCH_PERIPH, reg_num_t'(r), next_random(), 4);
	endtask

	task automatic test_scratch_reads();
		for (int r = 0; r < 4; r++)
			run_command(1'b1, SCRATCH_PERIPH, reg_num_t'(r), '0, 0);
	endtask

	// every marker value in the data bytes
	task automatic test_escaped_data();
		run_command(1'b0, SCRATCH_PERIPH, 8'd3, 32'h1B17_0155, 4);
		run_command(1'b1, SCRATCH_PERIPH, 8'd3, '0, 0);
	endtask

	task automatic test_unmapped();
		run_command(1'b1, 7'd5, 8'd0, '0, 0);
		run_command(1'b0, 7'd5, 8'd1, next_random(), 4);
	endtask

	task automatic test_framing_errors();
		// noise outside a frame, markers included
		cmd_wire.delete();
		cmd_wire.push_back(8'h55);
		cmd_wire.push_back(END_BYTE);
		cmd_wire.push_back(ESCAPE_BYTE);
		cmd_wire.push_back(8'hAA);
		cmd_wire.push_back(START_BYTE);
		push_escaped({1'b1, SCRATCH_PERIPH});
		push_escaped(8'd1);
		cmd_wire.push_back(END_BYTE);
		expect_scratch_read(8'd1);
		exchange(1'b1);
		// one body byte only
		cmd_wire.delete();
		cmd_wire.push_back(START_BYTE);
		push_escaped({1'b1, SCRATCH_PERIPH});
		cmd_wire.push_back(END_BYTE);
		exchange(1'b0);
		// second start byte drops the unmapped read
		cmd_wire.delete();
		cmd_wire.push_back(START_BYTE);
		push_escaped(8'h85);
		push_escaped(8'h00);
		cmd_wire.push_back(START_BYTE);
		push_escaped({1'b1, SCRATCH_PERIPH});
		push_escaped(8'd2);
		cmd_wire.push_back(END_BYTE);
		expect_scratch_read(8'd2);
		exchange(1'b1);
	endtask

	// run limit
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk_12MHz);
			cycle_count++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		int assert_errors;
		reset = 1'b1;
		uart_rx = 1'b1;
		for (int i = 0; i < 4; i++)
			shadow[i] = '0;
		repeat (4) @(posedge clk_12MHz);
		@(negedge clk_12MHz);
		reset = 1'b0;
		repeat (4) @(negedge clk_12MHz);
		test_idle_after_reset();
		test_scratch_writes();
		test_scratch_reads();
		test_escaped_data();
		test_unmapped();
		test_framing_errors();
		assert_errors = dut0.u_register_bus_master.u_bus_master_assertions.failures;
		$display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			value_errors, other_errors, assert_errors);
		if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/uniboard_assertions.sv
// register bus protocol assertions
`default_nettype none

module bus_master_assertions
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic bus_idle,
	input logic bus_select,
	input logic bus_rw,
	input reg_num_t bus_reg,
	input logic reply_valid
);

	// failure tally, read back by the testbench summary
	int failures = 0;

	// no select while the master says it is free
	select_when_busy: assert property (@(posedge clk_12MHz) disable iff (reset)
		bus_select |-> !bus_idle)
	else
	begin
		failures++;
		$error("bus_select high while bus_idle is high");
	end

	// direction and register held for the whole select window
	select_stable: assert property (@(posedge clk_12MHz) disable iff (reset)
		bus_select |=> (!bus_select || ($stable(bus_rw) && $stable(bus_reg))))
	else
	begin
		failures++;
		$error("bus_rw or bus_reg changed while bus_select high");
	end

	// reply handoff is a single pulse
	reply_pulse: assert property (@(posedge clk_12MHz) disable iff (reset)
		reply_valid |=> !reply_valid)
	else
	begin
		failures++;
		$error("reply_valid longer than one cycle");
	end

endmodule

bind register_bus_master bus_master_assertions u_bus_master_assertions (
	.clk_12MHz(clk_12MHz),
	.reset(reset),
	.bus_idle(bus_idle),
	.bus_select(bus_select),
	.bus_rw(bus_rw),
	.bus_reg(bus_reg),
	.reply_valid(reply_valid)
);

`default_nettype wire

// File: logic/uniboard_top.sv
// uniboard command path top level
`default_nettype none

module uniboard_top
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic uart_rx,
	output logic uart_tx
);

	// receive side
	byte_t rx_byte;
	logic rx_valid;
	logic cmd_valid;
	logic cmd_read;
	periph_num_t cmd_periph;
	reg_num_t cmd_reg;
	reg_data_t cmd_data;
	logic bus_idle;

	// register bus
	logic bus_rw;
	logic bus_select;
	periph_num_t bus_periph;
	reg_num_t bus_reg;
	reg_data_t bus_write_data;
	reg_data_t bus_read_data;
	reg_size_t bus_reg_size;

	// transmit side
	logic reply_valid;
	logic reply_read;
	periph_num_t reply_periph;
	reg_num_t reply_reg;
	reg_data_t reply_data;
	reg_size_t reply_size;
	logic reply_done;
	byte_t tx_byte;
	logic tx_send;
	logic tx_busy;

	uart_receiver u_uart_receiver (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.rx(uart_rx),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	frame_decoder u_frame_decoder (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.rx_valid(rx_valid),
		.bus_idle(bus_idle),
		.rx_byte(rx_byte),
		.cmd_valid(cmd_valid),
		.cmd_read(cmd_read),
		.cmd_periph(cmd_periph),
		.cmd_reg(cmd_reg),
		.cmd_data(cmd_data)
	);

	register_bus_master u_register_bus_master (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_read(cmd_read),
		.cmd_periph(cmd_periph),
		.cmd_reg(cmd_reg),
		.cmd_data(cmd_data),
		.bus_read_data(bus_read_data),
		.bus_reg_size(bus_reg_size),
		.bus_idle(bus_idle),
		.bus_rw(bus_rw),
		.bus_select(bus_select),
		.reply_valid(reply_valid),
		.bus_periph(bus_periph),
		.bus_reg(bus_reg),
		.bus_write_data(bus_write_data),
		.reply_read(reply_read),
		.reply_periph(reply_periph),
		.reply_reg(reply_reg),
		.reply_data(reply_data),
		.reply_size(reply_size),
		.reply_done(reply_done)
	);

	peripheral_block u_peripheral_block (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.bus_rw(bus_rw),
		.bus_select(bus_select),
		.bus_periph(bus_periph),
		.bus_reg(bus_reg),
		.bus_write_data(bus_write_data),
		.bus_read_data(bus_read_data),
		.bus_reg_size(bus_reg_size)
	);

	frame_encoder u_frame_encoder (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.reply_valid(reply_valid),
		.tx_busy(tx_busy),
		.reply_read(reply_read),
		.reply_periph(reply_periph),
		.reply_reg(reply_reg),
		.reply_data(reply_data),
		.reply_size(reply_size),
		.reply_done(reply_done),
		.tx_send(tx_send),
		.tx_byte(tx_byte)
	);

	uart_transmitter u_uart_transmitter (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.tx_send(tx_send),
		.tx_byte(tx_byte),
		.tx(uart_tx),
		.tx_busy(tx_busy)
	);

endmodule

`default_nettype wire

// File: logic/uart_transmitter.sv
// uart byte transmitter
`default_nettype none

module uart_transmitter
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic tx_send,
	input byte_t tx_byte,
	output logic tx,
	output logic tx_busy
);

	uart_tx_state_t tx_state;
	byte_t tx_shift;
	logic [$clog2(BAUD_DIV)-1:0] baud_count;
	logic [2:0] bit_index;
	logic bit_end;

	assign bit_end = (baud_count == BAUD_DIV - 1);

	// busy from the accepting edge to the end of the stop bit
	assign tx_busy = (tx_state != TX_IDLE);

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			tx_state <= TX_IDLE;
			tx <= 1'b1;
			baud_count <= '0;
			bit_index <= '0;
		end
		else
		begin
			if (tx_state == TX_IDLE || bit_end)
				baud_count <= '0;
			else
				baud_count <= baud_count + 1'b1;
			case (tx_state)
				TX_IDLE:
					if (tx_send)
					begin
						tx_shift <= tx_byte;
						// start bit
						tx <= 1'b0;
						tx_state <= TX_START;
					end
				TX_START:
					if (bit_end)
					begin
						tx <= tx_shift[0];
						tx_shift <= {1'b0, tx_shift[7:1]};
						bit_index <= '0;
						tx_state <= TX_DATA;
					end
				TX_DATA:
					if (bit_end)
					begin
						if (bit_index == 3'd7)
						begin
							// stop bit
							tx <= 1'b1;
							tx_state <= TX_STOP;
						end
						else
						begin
							tx <= tx_shift[0];
							tx_shift <= {1'b0, tx_shift[7:1]};
							bit_index <= bit_index + 1'b1;
						end
					end
				TX_STOP:
					if (bit_end)
						tx_state <= TX_IDLE;
				default:
					tx_state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/frame_encoder.sv
// reply frame encoder
`default_nettype none

module frame_encoder
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic reply_valid,
	input logic tx_busy,
	input logic reply_read,
	input periph_num_t reply_periph,
	input reg_num_t reply_reg,
	input reg_data_t reply_data,
	input reg_size_t reply_size,
	output logic reply_done,
	output logic tx_send,
	output byte_t tx_byte
);

	encode_state_t enc_state;
	logic [3:0] byte_index;
	logic [3:0] end_index;
	logic read_q;
	periph_num_t periph_q;
	reg_num_t reg_q;
	reg_size_t size_q;
	reg_data_t data_shift;
	byte_t current_byte;
	logic framing_byte;
	logic needs_escape;
	logic accept;
	logic byte_finished;

	assign accept = (enc_state == ENC_IDLE) && reply_valid;
	assign byte_finished = (enc_state == ENC_WAIT) && !tx_busy;

	// start, peripheral, register, data bytes, then end
	assign end_index = 4'd3 + {1'b0, size_q};

	always_comb
	begin
		framing_byte = 1'b0;
		// data bytes come off the bottom of the shift register
		current_byte = data_shift[7:0];
		if (byte_index == 4'd0)
		begin
			current_byte = START_BYTE;
			framing_byte = 1'b1;
		end
		else if (byte_index == 4'd1)
			current_byte = {read_q, periph_q};
		else if (byte_index == 4'd2)
			current_byte = reg_q;
		else if (byte_index == end_index)
		begin
			current_byte = END_BYTE;
			framing_byte = 1'b1;
		end
	end

	// body bytes that look like markers go out behind an escape
	assign needs_escape = !framing_byte
		&& ((current_byte == START_BYTE) || (current_byte == END_BYTE)
			|| (current_byte == ESCAPE_BYTE));

	always_ff @(posedge clk_12MHz)
	begin
		if (accept)
		begin
			read_q <= reply_read;
			periph_q <= reply_periph;
			reg_q <= reply_reg;
			size_q <= reply_size;
			data_shift <= reply_data;
		end
		else if (byte_finished && !framing_byte && (byte_index > 4'd2))
			data_shift <= data_shift >> 8;
		if (enc_state == ENC_PICK)
			tx_byte <= needs_escape ? ESCAPE_BYTE : current_byte;
		else if ((enc_state == ENC_ESC_WAIT) && !tx_busy)
			tx_byte <= current_byte;
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			enc_state <= ENC_IDLE;
			byte_index <= '0;
			tx_send <= 1'b0;
			reply_done <= 1'b0;
		end
		else
		begin
			reply_done <= 1'b0;
			case (enc_state)
				ENC_IDLE:
					if (accept)
					begin
						byte_index <= '0;
						enc_state <= ENC_PICK;
					end
				ENC_PICK:
				begin
					tx_send <= 1'b1;
					enc_state <= needs_escape ? ENC_ESC_HOLD : ENC_HOLD;
				end
				// hold send until the transmitter takes it, then wait it out
				ENC_ESC_HOLD:
					if (tx_busy)
					begin
						tx_send <= 1'b0;
						enc_state <= ENC_ESC_WAIT;
					end
				ENC_ESC_WAIT:
					if (!tx_busy)
					begin
						tx_send <= 1'b1;
						enc_state <= ENC_HOLD;
					end
				ENC_HOLD:
					if (tx_busy)
					begin
						tx_send <= 1'b0;
						enc_state <= ENC_WAIT;
					end
				ENC_WAIT:
					if (byte_finished)
					begin
						if (byte_index == end_index)
						begin
							// end byte fully on the wire
							reply_done <= 1'b1;
							enc_state <= ENC_IDLE;
						end
						else
						begin
							byte_index <= byte_index + 1'b1;
							enc_state <= ENC_PICK;
						end
					end
				default:
					enc_state <= ENC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/peripheral_block.sv
// scratch registers and default peripheral
`default_nettype none

module peripheral_block
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic bus_rw,
	input logic bus_select,
	input periph_num_t bus_periph,
	input reg_num_t bus_reg,
	input reg_data_t bus_write_data,
	output reg_data_t bus_read_data,
	output reg_size_t bus_reg_size
);

	reg_data_t scratch [4];
	logic select_q;
	logic scratch_hit;
	logic write_strobe;
	logic read_enable;

	assign scratch_hit = (bus_periph == SCRATCH_PERIPH);

	// writes land on the rising edge of select only
	assign write_strobe = bus_select && !select_q && !bus_rw && scratch_hit;
	assign read_enable = bus_select && bus_rw && scratch_hit;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			select_q <= 1'b0;
			for (int i = 0; i < 4; i++)
				scratch[i] <= '0;
		end
		else
		begin
			select_q <= bus_select;
			// low two register bits pick the word
			if (write_strobe)
				scratch[bus_reg[1:0]] <= bus_write_data;
		end
	end

	// unmapped peripherals answer with zero data and zero size
	assign bus_read_data = read_enable ? scratch[bus_reg[1:0]] : '0;
	assign bus_reg_size = read_enable ? SCRATCH_REG_SIZE : '0;

endmodule

`default_nettype wire

// File: logic/register_bus_master.sv
// register bus master
`default_nettype none

module register_bus_master
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic cmd_valid,
	input logic cmd_read,
	input periph_num_t cmd_periph,
	input reg_num_t cmd_reg,
	input reg_data_t cmd_data,
	input reg_data_t bus_read_data,
	input reg_size_t bus_reg_size,
	output logic bus_idle,
	output logic bus_rw,
	output logic bus_select,
	output logic reply_valid,
	output periph_num_t bus_periph,
	output reg_num_t bus_reg,
	output reg_data_t bus_write_data,
	// read flag of the command, echoed in the reply
	output logic reply_read,
	output periph_num_t reply_periph,
	output reg_num_t reply_reg,
	output reg_data_t reply_data,
	output reg_size_t reply_size,
	input logic reply_done
);

	bus_state_t bus_state;

	// only one command in flight, held until the reply is out
	assign bus_idle = (bus_state == BUS_IDLE);

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			bus_state <= BUS_IDLE;
			bus_select <= 1'b0;
			bus_rw <= 1'b1;
			reply_valid <= 1'b0;
		end
		else
		begin
			reply_valid <= 1'b0;
			case (bus_state)
				BUS_IDLE:
					if (cmd_valid)
					begin
						bus_rw <= cmd_read;
						bus_state <= cmd_read ? BUS_RD_SETUP : BUS_WR_SETUP;
					end
				// write: setup, two cycles selected, two cycles released
				BUS_WR_SETUP:
				begin
					bus_select <= 1'b1;
					bus_state <= BUS_WR_SEL1;
				end
				BUS_WR_SEL1:
					bus_state <= BUS_WR_SEL2;
				BUS_WR_SEL2:
				begin
					bus_select <= 1'b0;
					bus_state <= BUS_WR_GAP1;
				end
				BUS_WR_GAP1:
					bus_state <= BUS_WR_GAP2;
				BUS_WR_GAP2:
				begin
					// turn the bus around for the read-back
					bus_rw <= 1'b1;
					bus_state <= BUS_RD_SETUP;
				end
				BUS_RD_SETUP:
				begin
					bus_select <= 1'b1;
					bus_state <= BUS_RD_SEL1;
				end
				BUS_RD_SEL1:
					bus_state <= BUS_RD_SEL2;
				BUS_RD_SEL2:
				begin
					// data captured on this edge, see payload block
					bus_select <= 1'b0;
					reply_valid <= 1'b1;
					bus_state <= BUS_WAIT_DONE;
				end
				BUS_WAIT_DONE:
					if (reply_done)
						bus_state <= BUS_IDLE;
				default:
					bus_state <= BUS_IDLE;
			endcase
		end
	end

	// command fields and reply data
	always_ff @(posedge clk_12MHz)
	begin
		if (bus_idle && cmd_valid)
		begin
			bus_periph <= cmd_periph;
			bus_reg <= cmd_reg;
			bus_write_data <= cmd_data;
			reply_read <= cmd_read;
		end
		// last select cycle, peripheral output has settled
		if (bus_state == BUS_RD_SEL2)
		begin
			reply_data <= bus_read_data;
			reply_size <= bus_reg_size;
		end
	end

	// address stays put until the next command
	assign reply_periph = bus_periph;
	assign reply_reg = bus_reg;

endmodule

`default_nettype wire

// File: logic/frame_decoder.sv
// command frame decoder
`default_nettype none

module frame_decoder
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic rx_valid,
	input logic bus_idle,
	input byte_t rx_byte,
	output logic cmd_valid,
	output logic cmd_read,
	output periph_num_t cmd_periph,
	output reg_num_t cmd_reg,
	output reg_data_t cmd_data
);

	decode_state_t dec_state;
	byte_t body [BODY_MAX];
	logic [2:0] body_count;
	logic escape_pending;
	logic in_frame;
	logic clear_body;
	logic end_seen;
	logic escape_seen;
	logic take_data;

	assign in_frame = (dec_state == DEC_BODY);

	// unescaped start byte opens a frame, or restarts the open one
	assign clear_body = rx_valid && !escape_pending && (rx_byte == START_BYTE);
	assign end_seen = rx_valid && in_frame && !escape_pending && (rx_byte == END_BYTE);
	assign escape_seen = rx_valid && in_frame && !escape_pending && (rx_byte == ESCAPE_BYTE);

	// escaped bytes are always data, even marker values
	assign take_data = rx_valid && in_frame
		&& (escape_pending
			|| ((rx_byte != START_BYTE) && (rx_byte != END_BYTE) && (rx_byte != ESCAPE_BYTE)));

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			dec_state <= DEC_HUNT;
			body_count <= '0;
			escape_pending <= 1'b0;
			cmd_valid <= 1'b0;
		end
		else
		begin
			// short frames and frames that find the bus busy are dropped here
			cmd_valid <= end_seen && (body_count >= 3'd2) && bus_idle;
			if (clear_body)
			begin
				dec_state <= DEC_BODY;
				body_count <= '0;
				escape_pending <= 1'b0;
			end
			else if (end_seen)
				dec_state <= DEC_HUNT;
			else if (escape_seen)
				escape_pending <= 1'b1;
			else if (take_data)
			begin
				escape_pending <= 1'b0;
				// bytes past the sixth are thrown away
				if (body_count < BODY_MAX)
					body_count <= body_count + 1'b1;
			end
		end
	end

	// body buffer, zeroed per frame so missing write bytes read as zero
	always_ff @(posedge clk_12MHz)
	begin
		if (clear_body)
		begin
			for (int i = 0; i < BODY_MAX; i++)
				body[i] <= '0;
		end
		else if (take_data && (body_count < BODY_MAX))
			body[body_count] <= rx_byte;
	end

	// byte 0 is read flag plus peripheral, byte 1 the register
	assign cmd_read = body[0][7];
	assign cmd_periph = body[0][6:0];
	assign cmd_reg = body[1];
	// write data arrives low byte first
	assign cmd_data = {body[5], body[4], body[3], body[2]};

endmodule

`default_nettype wire

// File: logic/uart_receiver.sv
// uart byte receiver
`default_nettype none

module uart_receiver
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic rx,
	output byte_t rx_byte,
	output logic rx_valid
);

	uart_rx_state_t rx_state;
	logic rx_meta;
	logic rx_sync;
	logic [$clog2(BAUD_DIV)-1:0] baud_count;
	logic [2:0] bit_index;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			// line idles high
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_state <= RX_IDLE;
			baud_count <= '0;
			bit_index <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			// two flop synchronizer on the async pin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_valid <= 1'b0;
			case (rx_state)
				RX_IDLE:
				begin
					baud_count <= '0;
					// falling edge starts a character
					if (!rx_sync)
						rx_state <= RX_START;
				end
				RX_START:
					// half a bit in, start bit must still be low
					if (baud_count == BAUD_DIV / 2 - 1)
					begin
						baud_count <= '0;
						bit_index <= '0;
						if (!rx_sync)
							rx_state <= RX_DATA;
						else
							rx_state <= RX_IDLE;
					end
					else
						baud_count <= baud_count + 1'b1;
				RX_DATA:
					if (baud_count == BAUD_DIV - 1)
					begin
						baud_count <= '0;
						// lsb first, shift in from the top
						rx_byte <= {rx_sync, rx_byte[7:1]};
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7)
							rx_state <= RX_STOP;
					end
					else
						baud_count <= baud_count + 1'b1;
				RX_STOP:
					if (baud_count == BAUD_DIV - 1)
					begin
						baud_count <= '0;
						// strobe mid stop bit, drop the byte on a framing error
						rx_valid <= rx_sync;
						rx_state <= RX_IDLE;
					end
					else
						baud_count <= baud_count + 1'b1;
				default:
					rx_state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/uniboard_pkg.sv
// uniboard command path definitions
`default_nettype none

package uniboard_pkg;

	// widths that carry a meaning on the command path
	typedef logic [7:0] byte_t;
	typedef logic [6:0] periph_num_t;
	typedef logic [7:0] reg_num_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [2:0] reg_size_t;

	// 12 MHz clock, one bit every 12 cycles
	localparam int BAUD_DIV = 12;

	// frame markers
	localparam byte_t START_BYTE = 8'h01;
	localparam byte_t END_BYTE = 8'h17;
	localparam byte_t ESCAPE_BYTE = 8'h1B;

	// peripheral byte, register byte, four write data bytes
	localparam int BODY_MAX = 6;

	// scratch block location and register width in bytes
	localparam periph_num_t SCRATCH_PERIPH = 7'd2;
	localparam reg_size_t SCRATCH_REG_SIZE = 3'd4;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} uart_rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_tx_state_t;

	// hunting for a start byte, or inside a frame
	typedef enum logic {
		DEC_HUNT,
		DEC_BODY
	} decode_state_t;

	typedef enum logic [3:0] {
		BUS_IDLE,
		BUS_WR_SETUP,
		BUS_WR_SEL1,
		BUS_WR_SEL2,
		BUS_WR_GAP1,
		BUS_WR_GAP2,
		BUS_RD_SETUP,
		BUS_RD_SEL1,
		BUS_RD_SEL2,
		BUS_WAIT_DONE
	} bus_state_t;

	typedef enum logic [2:0] {
		ENC_IDLE,
		ENC_PICK,
		ENC_ESC_HOLD,
		ENC_ESC_WAIT,
		ENC_HOLD,
		ENC_WAIT
	} encode_state_t;

endpackage

`default_nettype wire
